/* include/sink_config.svh */
`ifndef SINK_CONFIG_SVH
`define SINK_CONFIG_SVH

// Stream side carries one word per beat.
`define SINK_STREAM_DW 32
// Memory bus is one word wider so a shifted word still fits.
`define SINK_MEM_DW (`SINK_STREAM_DW + 32)
// Byte address width.
`define SINK_ADDR_W 32
// Job length counter width.
`define SINK_CNT_W 16

`define SINK_STORE_FIFO_DEPTH 2 // 0 turns the store FIFO into plain wires.

// 1 places each word at its byte offset, 0 expects word-aligned addresses.
`define SINK_MISALIGNED 1

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_sink_streamer \
  -Mdir "$BUILD_DIR" -o tb_sink_streamer
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sink_streamer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0

/* sim/tb_sink_streamer.sv */
`timescale 1ns/10ps

module tb_sink_streamer import sink_pkg::*; ();

  localparam int NUM_JOBS = 14; // Jobs over all tests.
  localparam int MAX_LEN  = 24; // Longest job in elements.
  localparam int WDOG_CYC = NUM_JOBS * MAX_LEN * 40 + 2000;

  logic         clk_i;
  logic         rst_ni;
  sink_ctrl_t   ctrl_i;
  sink_stream_t stream_i;
  logic         stream_valid_i;
  logic         stream_ready_o;
  mem_store_t   mem_o;
  logic         mem_req_o;
  logic         mem_gnt_i;
  sink_flags_t  flags_o;

  sink_stream_t beat_q[$];              // Beats still to send.
  mem_store_t   exp_q[$];               // Stores the memory should see, in order.
  logic [7:0]   ref_mem[int unsigned];  // Expected image.
  logic [7:0]   dut_mem[int unsigned];  // Image written through the port.
  int           gap_pct;                // Chance of an idle stream cycle.
  int           gnt_pct;                // Chance of a grant.
  int           beats_taken;
  int           stores_seen;
  int           errors;                 // Errors of the running test.
  int           total_errors;
  int           tests_run;
  int           tests_failed;
  logic         beat_taken;
  logic         held_req;               // Request left waiting last cycle.
  mem_store_t   held_store;

  sink_streamer_top sink_streamer_top_inst (.*);

  always #5 clk_i = ~clk_i;

  // Stream source. Holds a beat until the DUT takes it.
  always @(posedge clk_i) begin
    beat_taken = stream_valid_i && stream_ready_o;
    if (beat_taken) begin
      beat_q.delete(0);
      beats_taken++;
    end
    #1;
    if (beat_q.size() == 0) begin
      stream_valid_i = 1'b0;
    end else if (beat_taken || !stream_valid_i) begin
      stream_i       = beat_q[0];
      stream_valid_i = ($urandom_range(99) >= gap_pct);
    end
  end

  // Memory side. Random grant, byte-enabled writes.
  always @(posedge clk_i) begin
    if (rst_ni && held_req) begin
      assert (mem_req_o && mem_o == held_store) else begin
        $display("** Error: %0d ns: store request dropped or changed before its grant", $time);
        errors++;
      end
    end
    held_req   = rst_ni && mem_req_o && !mem_gnt_i;
    held_store = mem_o;
    if (rst_ni && mem_req_o && mem_gnt_i) record_store(mem_o);
    #1;
    mem_gnt_i = ($urandom_range(99) < gnt_pct);
  end

  task automatic record_store(input mem_store_t st);
    mem_store_t exp;
    stores_seen++;
    assert (exp_q.size() != 0) else begin
      $display("** Error: %0d ns: extra store to %h with no store expected", $time, st.addr);
      errors++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      assert (st == exp) else begin
        $display("** Error: %0d ns: store %h/%h/%h, expected %h/%h/%h", $time,
                 st.addr, st.be, st.data, exp.addr, exp.be, exp.data);
        errors++;
      end
    end
    for (int b = 0; b < 8; b++) begin
      if (st.be[b]) dut_mem[st.addr + b] = st.data[8*b +: 8];
    end
  endtask

  // Expected stores and image, straight from the address rule.
  task automatic build_job(input sink_ctrl_t cfg, input bit rand_strb);
    logic [31:0]  a;
    sink_stream_t beat;
    mem_store_t   st;
    int unsigned  line;
    int unsigned  pos;
    ref_mem.delete();
    dut_mem.delete();
    for (int k = 0; k < cfg.tot_len; k++) begin
      line      = k / cfg.d0_len;
      pos       = k % cfg.d0_len;
      a         = cfg.base_addr + pos * cfg.d0_stride + line * cfg.d1_stride;
      beat.data = $urandom();
      beat.strb = rand_strb ? 4'($urandom_range(15)) : 4'hF;
      st.addr   = {a[31:2], 2'b00};
      st.be     = 8'(beat.strb) << a[1:0];    // Strobes move with the data.
      st.data   = 64'(beat.data) << (8 * a[1:0]);
      for (int b = 0; b < 8; b++) begin
        if (st.be[b]) ref_mem[st.addr + b] = st.data[8*b +: 8];
      end
      beat_q.push_back(beat);
      exp_q.push_back(st);
    end
  endtask

  task automatic run_job(input sink_ctrl_t cfg, input bit rand_strb);
    sink_ctrl_t go;
    @(negedge clk_i);
    build_job(cfg, rand_strb);
    beats_taken = 0;
    stores_seen = 0;
    assert (flags_o.ready_start) else begin
      $display("** Error: %0d ns: ready_start is low between jobs", $time);
      errors++;
    end
    go           = cfg;
    go.req_start = 1'b1;
    @(posedge clk_i);
    #1 ctrl_i = go;
    @(posedge clk_i);
    #1 ctrl_i.req_start = 1'b0; // One-cycle start pulse.
    @(posedge clk_i);
    while (!flags_o.done) begin
      assert (!flags_o.ready_start) else begin
        $display("** Error: %0d ns: ready_start is high during a job", $time);
        errors++;
      end
      @(posedge clk_i);
    end
    assert (beats_taken == cfg.tot_len) else begin
      $display("** Error: %0d ns: done after %0d of %0d beats", $time, beats_taken, cfg.tot_len);
      errors++;
    end
    @(posedge clk_i);
    assert (!flags_o.done) else begin
      $display("** Error: %0d ns: done is high for more than one cycle", $time);
      errors++;
    end
    while (exp_q.size() != 0) @(posedge clk_i); // Store FIFO drains.
    repeat (4) @(posedge clk_i);                 // Room for a duplicate to show.
    assert (stores_seen == cfg.tot_len) else begin
      $display("** Error: %0d ns: %0d stores, expected %0d", $time, stores_seen, cfg.tot_len);
      errors++;
    end
    foreach (ref_mem[addr]) begin
      assert (dut_mem.exists(addr) && dut_mem[addr] == ref_mem[addr]) else begin
        $display("** Error: %0d ns: memory byte %h differs from the model", $time, addr);
        errors++;
      end
    end
    assert (dut_mem.size() == ref_mem.size()) else begin
      $display("** Error: %0d ns: memory holds bytes the model never wrote", $time);
      errors++;
    end
  endtask

  task automatic apply_reset();
    #1 rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    assert (!mem_req_o && !stream_ready_o && !flags_o.done && flags_o.ready_start) else begin
      $display("** Error: %0d ns: outputs not at their reset values", $time);
      errors++;
    end
    #1 rst_ni = 1'b1;
  endtask

  function automatic sink_ctrl_t rand_cfg();
    sink_ctrl_t c;
    c           = '0;
    c.base_addr = 32'h0000_4000 + $urandom_range(255);
    c.d0_stride = $urandom_range(12);
    c.d0_len    = 16'($urandom_range(5, 1));
    c.d1_stride = $urandom_range(64);
    c.tot_len   = 16'($urandom_range(MAX_LEN, 1));
    return c;
  endfunction

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name,
             (errors == 0) ? "passed" : "failed", errors);
    total_errors += errors;
    errors = 0;
  endtask

  initial begin
    sink_ctrl_t cfg;
    void'($urandom(32'hc120_b561));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    ctrl_i         = '0;
    stream_i       = '0;
    stream_valid_i = 1'b0;
    mem_gnt_i      = 1'b0;
    gap_pct        = 0;
    gnt_pct        = 100;
    errors         = 0;
    total_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    held_req       = 1'b0;
    apply_reset();

    repeat (2) begin
      cfg           = '0;
      cfg.base_addr = 32'h0000_1000 + 4 * $urandom_range(63);
      cfg.d0_stride = 4;
      cfg.tot_len   = 16'($urandom_range(MAX_LEN, 8));
      cfg.d0_len    = cfg.tot_len; // One line.
      run_job(cfg, 1'b0);
    end
    finish_test("aligned contiguous");

    gnt_pct = 70;
    for (int off = 1; off <= 3; off++) begin
      cfg           = '0;
      cfg.base_addr = 32'h0000_2000 + 4 * $urandom_range(63) + off;
      cfg.d0_stride = 4;
      cfg.tot_len   = 16'($urandom_range(MAX_LEN, 4));
      cfg.d0_len    = cfg.tot_len;
      run_job(cfg, 1'b0);
    end
    finish_test("misaligned base");

    gnt_pct = 100;
    repeat (4) run_job(rand_cfg(), 1'b0);
    finish_test("two-level pattern");

    gap_pct = 40;
    gnt_pct = 50;
    repeat (4) run_job(rand_cfg(), 1'b1);
    finish_test("stalls and gaps");

    gap_pct = 20;
    gnt_pct = 60;
    apply_reset();
    @(posedge clk_i);
    assert (!mem_req_o && !stream_ready_o && flags_o.ready_start) else begin
      $display("** Error: %0d ns: outputs not idle after reset release", $time);
      errors++;
    end
    run_job(rand_cfg(), 1'b0);
    finish_test("flags");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors);
    if (tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk_i);
    $display("Timeout: the jobs did not complete within %0d cycles", WDOG_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* src/addr_fifo.sv */
`timescale 1ns/10ps

module addr_fifo import sink_pkg::*; #(
  parameter int unsigned DEPTH = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  sink_addr_u push_i,
  input  logic       push_valid_i,
  output logic       push_ready_o,
  output sink_addr_u pop_o,
  output logic       pop_valid_o,
  input  logic       pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  sink_addr_u       buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q; // Entries held.
  logic             push;
  logic             pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH)); // Low when full.
  assign pop_valid_o  = (count_q != '0);
  assign pop_o        = buf_q[rd_ptr_q];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) buf_q[wr_ptr_q] <= push_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Equal pointers mean empty or full, never a partial fill.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_ptr_q == rd_ptr_q) |-> (count_q == '0) || (count_q == CNT_W'(DEPTH)));
  // A head entry that is not taken stays put.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_o));

endmodule

/* src/mem_store_fifo.sv */
`timescale 1ns/10ps

module mem_store_fifo import sink_pkg::*; #(
  parameter int unsigned DEPTH = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  mem_store_t in_i,
  input  logic       in_req_i,
  output logic       in_gnt_o,
  output mem_store_t out_o,
  output logic       out_req_o,
  input  logic       out_gnt_i
);

  generate
    if (DEPTH == 0) begin : gen_direct
      assign out_o     = in_i;
      assign out_req_o = in_req_i;
      assign in_gnt_o  = out_gnt_i;
    end else begin : gen_buffered
      localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
      localparam int unsigned CNT_W = $clog2(DEPTH + 1);

      mem_store_t       slot_q [DEPTH];
      logic [PTR_W-1:0] head_q;  // Oldest store.
      logic [PTR_W-1:0] tail_q;  // Next free slot.
      logic [CNT_W-1:0] fill_q;
      logic             put;
      logic             take;

      assign in_gnt_o  = (fill_q != CNT_W'(DEPTH)); // Grant whenever there is room.
      assign out_req_o = (fill_q != '0);
      assign out_o     = slot_q[head_q];
      assign put       = in_req_i & in_gnt_o;
      assign take      = out_req_o & out_gnt_i;

      always_ff @(posedge clk_i) begin
        if (put) slot_q[tail_q] <= in_i;
      end

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          head_q <= '0;
          tail_q <= '0;
          fill_q <= '0;
        end else begin
          if (put) tail_q <= (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
          if (take) head_q <= (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
          fill_q <= fill_q + CNT_W'(put) - CNT_W'(take);
        end
      end
    end
  endgenerate

  // Memory sees a steady request until it grants.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_o && !out_gnt_i |=> out_req_o && $stable(out_o));

endmodule

/* src/sink_pkg.sv */
`include "sink_config.svh"

package sink_pkg;

  // Byte address split into word index and byte offset.
  typedef struct packed {
    logic [`SINK_ADDR_W-3:0] word;   // Word index.
    logic [1:0]              offset; // Byte within the word.
  } sink_addr_fields_t;

  typedef union packed {
    logic [`SINK_ADDR_W-1:0] raw; // Plain byte address.
    sink_addr_fields_t       fields;
  } sink_addr_u;

  typedef struct packed {
    logic [`SINK_STREAM_DW-1:0]   data;
    logic [`SINK_STREAM_DW/8-1:0] strb; // One strobe per byte.
  } sink_stream_t;

  // Store request toward memory.
  typedef struct packed {
    logic [`SINK_ADDR_W-1:0]   addr; // Always word-aligned.
    logic [`SINK_MEM_DW/8-1:0] be;
    logic [`SINK_MEM_DW-1:0]   data;
  } mem_store_t;

  typedef struct packed {
    logic                    req_start;
    logic [`SINK_ADDR_W-1:0] base_addr; // First element.
    logic [`SINK_ADDR_W-1:0] d0_stride; // Step inside a line.
    logic [`SINK_CNT_W-1:0]  d0_len;    // Elements per line.
    logic [`SINK_ADDR_W-1:0] d1_stride; // Step between line starts.
    logic [`SINK_CNT_W-1:0]  tot_len;   // Elements in the job.
  } sink_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
  } sink_flags_t;

  typedef enum logic [1:0] {IDLE, WORKING, DRAIN} sink_state_e;

endpackage

/* src/sink_streamer_top.sv */
`timescale 1ns/10ps
`include "sink_config.svh"

module sink_streamer_top import sink_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  sink_ctrl_t   ctrl_i,
  input  sink_stream_t stream_i,
  input  logic         stream_valid_i,
  output logic         stream_ready_o,
  output mem_store_t   mem_o,
  output logic         mem_req_o,
  input  logic         mem_gnt_i,
  output sink_flags_t  flags_o
);

  sink_addr_u gen_addr;
  sink_addr_u fifo_addr;
  logic       gen_start;
  logic       gen_valid;
  logic       gen_last;
  logic       fifo_push_ready;
  logic       fifo_valid;
  logic       sink_addr_ready;
  logic       sink_busy;
  logic       last_xfer;
  mem_store_t store;
  logic       store_req;
  logic       store_gnt;

  assign gen_start = ctrl_i.req_start & ~sink_busy;          // Start only from idle.
  assign last_xfer = gen_last & gen_valid & fifo_push_ready; // Final address accepted.

  store_addr_gen store_addr_gen_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (gen_start),
    .ctrl_i       (ctrl_i),
    .addr_ready_i (fifo_push_ready),
    .addr_o       (gen_addr),
    .addr_valid_o (gen_valid),
    .last_o       (gen_last)
  );

  addr_fifo #(
    .DEPTH (2)
  ) addr_fifo_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (gen_addr),
    .push_valid_i (gen_valid),
    .push_ready_o (fifo_push_ready),
    .pop_o        (fifo_addr),
    .pop_valid_o  (fifo_valid),
    .pop_ready_i  (sink_addr_ready)
  );

  store_sink store_sink_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl_i),
    .addr_i         (fifo_addr),
    .addr_valid_i   (fifo_valid),
    .addr_last_i    (last_xfer),
    .addr_ready_o   (sink_addr_ready),
    .stream_i       (stream_i),
    .stream_valid_i (stream_valid_i),
    .stream_ready_o (stream_ready_o),
    .store_o        (store),
    .store_req_o    (store_req),
    .store_gnt_i    (store_gnt),
    .busy_o         (sink_busy),
    .flags_o        (flags_o)
  );

  mem_store_fifo #(
    .DEPTH (`SINK_STORE_FIFO_DEPTH)
  ) mem_store_fifo_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_i      (store),
    .in_req_i  (store_req),
    .in_gnt_o  (store_gnt),
    .out_o     (mem_o),
    .out_req_o (mem_req_o),
    .out_gnt_i (mem_gnt_i)
  );

endmodule

/* src/store_addr_gen.sv */
`timescale 1ns/10ps
`include "sink_config.svh"

module store_addr_gen import sink_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  sink_ctrl_t ctrl_i,
  input  logic       addr_ready_i,
  output sink_addr_u addr_o,
  output logic       addr_valid_o,
  output logic       last_o
);

  logic                    active_q;    // An address is on offer.
  logic [`SINK_CNT_W-1:0]  elem_q;      // Element index k.
  logic [`SINK_CNT_W-1:0]  pos_q;       // Position i inside the current line.
  logic [`SINK_ADDR_W-1:0] line_base_q; // Start address of the current line.
  logic [`SINK_ADDR_W-1:0] addr_q;
  logic                    xfer;
  logic                    line_end;

  assign xfer         = active_q & addr_ready_i;
  assign line_end     = (pos_q == ctrl_i.d0_len - 1'b1);
  assign last_o       = active_q & (elem_q == ctrl_i.tot_len - 1'b1);
  assign addr_valid_o = active_q;
  assign addr_o.raw   = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      elem_q   <= '0;
      pos_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1; // First address next cycle.
      elem_q   <= '0;
      pos_q    <= '0;
    end else if (xfer) begin
      if (last_o) begin
        active_q <= 1'b0; // Stop once the final address has left.
      end
      elem_q <= elem_q + 1'b1;
      pos_q  <= line_end ? '0 : pos_q + 1'b1;
    end
  end

  // Running address. Adds d0_stride inside a line, jumps a line on wrap.
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      line_base_q <= ctrl_i.base_addr;
      addr_q      <= ctrl_i.base_addr;
    end else if (xfer) begin
      if (line_end) begin
        line_base_q <= line_base_q + ctrl_i.d1_stride;
        addr_q      <= line_base_q + ctrl_i.d1_stride;
      end else begin
        addr_q <= addr_q + ctrl_i.d0_stride;
      end
    end
  end

  // The sink only lets a job start after the previous sequence has ended.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !active_q && (ctrl_i.d0_len != '0));

endmodule

/* src/store_sink.sv */
`timescale 1ns/10ps
`include "sink_config.svh"

module store_sink import sink_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  sink_ctrl_t   ctrl_i,
  input  sink_addr_u   addr_i,
  input  logic         addr_valid_i,
  input  logic         addr_last_i,   // Last address is moving out of the generator.
  output logic         addr_ready_o,
  input  sink_stream_t stream_i,
  input  logic         stream_valid_i,
  output logic         stream_ready_o,
  output mem_store_t   store_o,
  output logic         store_req_o,
  input  logic         store_gnt_i,
  output logic         busy_o,
  output sink_flags_t  flags_o
);

  localparam int unsigned BE_W = `SINK_MEM_DW / 8;

  sink_state_e             cs;
  sink_state_e             ns;
  logic [`SINK_CNT_W-1:0]  cnt_q;  // Addresses consumed in this job.
  logic                    last_q; // Generator has handed over its final address.
  logic                    done_q;
  logic                    finish;
  logic                    store_xfer;
  logic [`SINK_MEM_DW-1:0] data_wide;
  logic [BE_W-1:0]         be_wide;
  logic [`SINK_MEM_DW-1:0] data_sh;
  logic [BE_W-1:0]         be_sh;

  assign busy_o      = (cs != IDLE);
  assign store_req_o = busy_o & stream_valid_i & addr_valid_i; // Needs both halves.
  assign store_xfer  = store_req_o & store_gnt_i;

  // Each side is taken only when the other is there too.
  assign stream_ready_o = busy_o & addr_valid_i & store_gnt_i;
  assign addr_ready_o   = busy_o & stream_valid_i & store_gnt_i;

  // Word goes in the low half of the bus before shifting.
  assign data_wide = {{(`SINK_MEM_DW - `SINK_STREAM_DW){1'b0}}, stream_i.data};
  assign be_wide   = {{(BE_W - `SINK_STREAM_DW / 8){1'b0}}, stream_i.strb};

  generate
    if (`SINK_MISALIGNED == 1) begin : gen_misaligned
      assign data_sh = data_wide << {addr_i.fields.offset, 3'b000}; // Offset in bytes.
      assign be_sh   = be_wide << addr_i.fields.offset;
    end else begin : gen_aligned
      assign data_sh = data_wide;
      assign be_sh   = be_wide;
    end
  endgenerate

  assign store_o = '{addr: {addr_i.fields.word, 2'b00}, be: be_sh, data: data_sh};

  always_comb begin
    ns     = cs;
    finish = 1'b0;
    case (cs)
      IDLE: begin
        if (ctrl_i.req_start) ns = WORKING;
      end
      WORKING: begin
        if (last_q) ns = DRAIN; // No more addresses will be generated.
      end
      DRAIN: begin
        if (cnt_q == ctrl_i.tot_len) begin
          ns     = IDLE;
          finish = 1'b1;
        end
      end
      default: ns = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs     <= IDLE;
      cnt_q  <= '0;
      last_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      cs     <= ns;
      done_q <= finish; // High the cycle after leaving DRAIN.
      if (finish) begin
        cnt_q  <= '0;
        last_q <= 1'b0;
      end else begin
        if (store_xfer) cnt_q <= cnt_q + 1'b1;
        if (addr_last_i) last_q <= 1'b1;
      end
    end
  end

  assign flags_o = '{ready_start: (cs == IDLE), done: done_q};

  // A consumed pair never goes past the job length.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_xfer |-> (cnt_q < ctrl_i.tot_len));
  // The final address arrives while the job is still running.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_last_i |-> (cs == WORKING));

endmodule

/* vlog.f */
+incdir+include
src/sink_pkg.sv
src/store_addr_gen.sv
src/addr_fifo.sv
src/store_sink.sv
src/mem_store_fifo.sv
src/sink_streamer_top.sv
sim/tb_sink_streamer.sv
